/* design/sw_align_top.sv */
`timescale 1ns/100ps

module sw_align_top
    import sw_pkg::*;
#(
    parameter int P_NUM_PE     = 8,
    parameter int P_GAP_OPEN   = -12,
    parameter int P_GAP_EXTEND = -1,
    parameter int P_XDROP      = 250
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_job_req,
    input  base_t [P_NUM_PE-1:0] i_query,
    output logic                 o_job_ack,
    input  logic                 i_sym_req,
    input  sym_t                 i_sym,
    output logic                 o_sym_ack,
    output logic                 o_res_req,
    output align_result_t        o_res,
    input  logic                 i_res_ack
);

    logic                  load;
    logic                  step;
    logic                  eval;
    logic                  clear;
    base_t                 feed;
    logic                  feed_valid;
    step_t                 step_num;
    logic                  stop;
    align_result_t         best;
    score_t [P_NUM_PE-1:0] step_v;
    score_t                step_max;
    row_t                  step_row;

    sw_ctrl #(
        .P_NUM_PE (P_NUM_PE)
    ) u_sw_ctrl (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_job_req    (i_job_req),
        .o_job_ack    (o_job_ack),
        .i_sym_req    (i_sym_req),
        .i_sym        (i_sym),
        .o_sym_ack    (o_sym_ack),
        .o_res_req    (o_res_req),
        .o_res        (o_res),
        .i_res_ack    (i_res_ack),
        .i_stop       (stop),
        .i_best       (best),
        .o_load       (load),
        .o_step       (step),
        .o_eval       (eval),
        .o_clear      (clear),
        .o_feed       (feed),
        .o_feed_valid (feed_valid),
        .o_step_num   (step_num)
    );

    sw_pe_array #(
        .P_NUM_PE     (P_NUM_PE),
        .P_GAP_OPEN   (P_GAP_OPEN),
        .P_GAP_EXTEND (P_GAP_EXTEND)
    ) u_sw_pe_array (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_load       (load),
        .i_step       (step),
        .i_query      (i_query),
        .i_feed       (feed),
        .i_feed_valid (feed_valid),
        .o_step_v     (step_v)
    );

    sw_max_tree #(
        .P_NUM_PE (P_NUM_PE)
    ) u_sw_max_tree (
        .i_scores (step_v),
        .o_max    (step_max),
        .o_row    (step_row)
    );

    sw_best_tracker #(
        .P_XDROP (P_XDROP)
    ) u_sw_best_tracker (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_clear    (clear),
        .i_eval     (eval),
        .i_step_num (step_num),
        .i_step_max (step_max),
        .i_step_row (step_row),
        .o_best     (best),
        .o_stop     (stop)
    );

endmodule

/* design/sw_best_tracker.sv */
`timescale 1ns/100ps

module sw_best_tracker
    import sw_pkg::*;
#(
    parameter int P_XDROP = 250
) (
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_clear,
    input  logic          i_eval,
    input  step_t         i_step_num,
    input  score_t        i_step_max,
    input  row_t          i_step_row,
    output align_result_t o_best,
    output logic          o_stop
);

    score_t best_score;
    row_t   best_row;
    step_t  best_col;
    score_t limit;
    step_t  cand_col;

    // threshold against the best before this step
    assign limit    = best_score - score_t'(P_XDROP);
    // row r works on column step - r
    assign cand_col = i_step_num - step_t'(i_step_row);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            best_score <= NEG_INF;
            best_row   <= '0;
            best_col   <= '0;
            o_stop     <= 1'b0;
        end else if (i_clear) begin
            best_score <= NEG_INF;
            best_row   <= '0;
            best_col   <= '0;
            o_stop     <= 1'b0;
        end else if (i_eval && !o_stop) begin
            // later steps win ties
            if (i_step_max >= best_score) begin
                best_score <= i_step_max;
                best_row   <= i_step_row;
                best_col   <= cand_col;
            end
            if (i_step_max < limit) begin
                o_stop <= 1'b1;
            end
        end
    end

    // end_step and the flag are filled in by the controller
    assign o_best = '{
        score:     best_score,
        row:       best_row,
        col:       best_col,
        end_step:  '0,
        xdrop_hit: 1'b0
    };

endmodule

/* design/sw_ctrl.sv */
`timescale 1ns/100ps

module sw_ctrl
    import sw_pkg::*;
#(
    parameter int P_NUM_PE = 8
) (
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_job_req,
    output logic          o_job_ack,
    input  logic          i_sym_req,
    input  sym_t          i_sym,
    output logic          o_sym_ack,
    output logic          o_res_req,
    output align_result_t o_res,
    input  logic          i_res_ack,
    input  logic          i_stop,
    input  align_result_t i_best,
    output logic          o_load,
    output logic          o_step,
    output logic          o_eval,
    output logic          o_clear,
    output base_t         o_feed,
    output logic          o_feed_valid,
    output step_t         o_step_num
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RUN,
        ST_FLUSH,
        ST_DRAIN,
        ST_RESULT
    } state_t;

    state_t state;
    step_t  step_cnt;
    step_t  eval_num;
    step_t  done_num;
    row_t   flush_cnt;
    logic   drain_done;
    logic   sym_take;

    assign sym_take   = (state == ST_RUN) && i_sym_req && !o_sym_ack;
    // nothing left in flight once step and eval are both low
    assign drain_done = (state == ST_DRAIN) && !o_step && !o_eval;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state        <= ST_IDLE;
            o_job_ack    <= 1'b0;
            o_sym_ack    <= 1'b0;
            o_res_req    <= 1'b0;
            o_load       <= 1'b0;
            o_clear      <= 1'b0;
            o_step       <= 1'b0;
            o_eval       <= 1'b0;
            o_feed_valid <= 1'b0;
            step_cnt     <= '0;
            eval_num     <= '0;
            done_num     <= '0;
            flush_cnt    <= '0;
        end else begin
            o_load   <= 1'b0;
            o_clear  <= 1'b0;
            o_step   <= 1'b0;
            o_eval   <= o_step;
            eval_num <= step_cnt;
            // last step evaluated before any stop
            if (o_eval && !i_stop) begin
                done_num <= eval_num;
            end
            if (o_job_ack && !i_job_req) begin
                o_job_ack <= 1'b0;
            end
            if (o_sym_ack && !i_sym_req) begin
                o_sym_ack <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    if (i_job_req && !o_job_ack) begin
                        o_job_ack <= 1'b1;
                        o_load    <= 1'b1;
                        o_clear   <= 1'b1;
                        step_cnt  <= '0;
                        state     <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (sym_take) begin
                        o_sym_ack <= 1'b1;
                        // after a stop the symbol is acked and dropped
                        if (!i_stop) begin
                            o_step       <= 1'b1;
                            o_feed_valid <= 1'b1;
                            step_cnt     <= step_cnt + 1'b1;
                        end
                        if (i_sym.last) begin
                            flush_cnt <= row_t'(P_NUM_PE - 1);
                            state     <= i_stop ? ST_DRAIN : ST_FLUSH;
                        end
                    end
                end
                ST_FLUSH: begin
                    o_feed_valid <= 1'b0;
                    if (i_stop || flush_cnt == '0) begin
                        state <= ST_DRAIN;
                    end else begin
                        o_step    <= 1'b1;
                        step_cnt  <= step_cnt + 1'b1;
                        flush_cnt <= flush_cnt - 1'b1;
                    end
                end
                ST_DRAIN: begin
                    if (drain_done) begin
                        o_res_req <= 1'b1;
                        state     <= ST_RESULT;
                    end
                end
                ST_RESULT: begin
                    if (o_res_req && i_res_ack) begin
                        o_res_req <= 1'b0;
                    end else if (!o_res_req && !i_res_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (sym_take) begin
            o_feed <= i_sym.base;
        end
        if (drain_done) begin
            o_res <= '{
                score:     i_best.score,
                row:       i_best.row,
                col:       i_best.col,
                end_step:  done_num,
                xdrop_hit: i_stop
            };
        end
    end

    assign o_step_num = eval_num;

endmodule

/* design/sw_max_tree.sv */
`timescale 1ns/100ps

module sw_max_tree
    import sw_pkg::*;
#(
    parameter int P_NUM_PE = 8
) (
    input  score_t [P_NUM_PE-1:0] i_scores,
    output score_t                o_max,
    output row_t                  o_row
);

    localparam int     LEVELS = (P_NUM_PE > 1) ? $clog2(P_NUM_PE) : 0;
    localparam int     WIDTH  = 1 << LEVELS;
    // below NEG_INF so padding never beats a real row
    localparam score_t PAD    = NEG_INF - 14'sd1;

    // heap order, root at 1, leaves from WIDTH
    score_t node_v [1:2*WIDTH-1];
    row_t   node_r [1:2*WIDTH-1];

    for (genvar k = 0; k < WIDTH; k++) begin : g_leaf
        if (k < P_NUM_PE) begin : g_real
            assign node_v[WIDTH+k] = i_scores[k];
        end else begin : g_pad
            assign node_v[WIDTH+k] = PAD;
        end
        assign node_r[WIDTH+k] = row_t'(k);
    end

    for (genvar n = 1; n < WIDTH; n++) begin : g_node
        logic pick_hi;

        // upper half holds the higher rows, so it takes ties
        assign pick_hi   = node_v[2*n+1] >= node_v[2*n];
        assign node_v[n] = pick_hi ? node_v[2*n+1] : node_v[2*n];
        assign node_r[n] = pick_hi ? node_r[2*n+1] : node_r[2*n];
    end

    assign o_max = node_v[1];
    assign o_row = node_r[1];

endmodule

/* design/sw_pe.sv */
`timescale 1ns/100ps

module sw_pe
    import sw_pkg::*;
#(
    parameter int P_ROW        = 0,
    parameter int P_GAP_OPEN   = -12,
    parameter int P_GAP_EXTEND = -1
) (
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_load,
    input  logic   i_step,
    input  base_t  i_row_base,
    input  base_t  i_col,
    input  logic   i_col_valid,
    input  cell_t  i_top,
    input  score_t i_diag,
    output cell_t  o_cell,
    output score_t o_diag,
    output base_t  o_col,
    output logic   o_col_valid
);

    localparam score_t OPEN_EXT  = score_t'(P_GAP_OPEN + P_GAP_EXTEND);
    localparam score_t EXT       = score_t'(P_GAP_EXTEND);
    // H(row, 0) for this cell's row
    localparam score_t LEFT_INIT = score_t'(P_GAP_OPEN + P_GAP_EXTEND * (P_ROW + 1));

    base_t  row_base_q;
    cell_t  cell_q;
    score_t diag_q;
    base_t  col_q;
    logic   col_valid_q;

    score_t sub;
    score_t i_new;
    score_t d_new;
    score_t v_new;
    logic   compute;

    assign compute = i_step && i_col_valid;

    always_comb begin
        sub = (row_base_q == i_col) ? MATCH_SCORE : MISMATCH_SCORE;

        // gap along the row, from the left
        i_new = cell_q.v + OPEN_EXT;
        if (cell_q.i + EXT > i_new) begin
            i_new = cell_q.i + EXT;
        end

        // gap along the column, from above
        d_new = i_top.v + OPEN_EXT;
        if (i_top.d + EXT > d_new) begin
            d_new = i_top.d + EXT;
        end

        v_new = i_diag + sub;
        if (i_new > v_new) begin
            v_new = i_new;
        end
        if (d_new > v_new) begin
            v_new = d_new;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            row_base_q <= i_row_base;
            cell_q.v   <= LEFT_INIT;
            cell_q.i   <= NEG_INF;
            cell_q.d   <= NEG_INF;
            diag_q     <= LEFT_INIT;
        end else if (compute) begin
            cell_q.v <= v_new;
            cell_q.i <= i_new;
            cell_q.d <= d_new;
            // old V becomes the diagonal for the row below
            diag_q   <= cell_q.v;
        end
        if (i_step) begin
            col_q <= i_col;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            col_valid_q <= 1'b0;
        end else if (i_load) begin
            col_valid_q <= 1'b0;
        end else if (i_step) begin
            col_valid_q <= i_col_valid;
        end
    end

    assign o_cell      = cell_q;
    assign o_diag      = diag_q;
    assign o_col       = col_q;
    assign o_col_valid = col_valid_q;

endmodule

/* design/sw_pe_array.sv */
`timescale 1ns/100ps

module sw_pe_array
    import sw_pkg::*;
#(
    parameter int P_NUM_PE     = 8,
    parameter int P_GAP_OPEN   = -12,
    parameter int P_GAP_EXTEND = -1
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_load,
    input  logic                  i_step,
    input  base_t [P_NUM_PE-1:0]  i_query,
    input  base_t                 i_feed,
    input  logic                  i_feed_valid,
    output score_t [P_NUM_PE-1:0] o_step_v
);

    localparam score_t OPEN_EXT = score_t'(P_GAP_OPEN + P_GAP_EXTEND);
    localparam score_t EXT      = score_t'(P_GAP_EXTEND);

    step_t  col_cnt;
    score_t h0_q;
    cell_t  top_cell;
    score_t top_diag;

    cell_t  pe_cell      [P_NUM_PE];
    score_t pe_diag      [P_NUM_PE];
    base_t  pe_col       [P_NUM_PE];
    logic   pe_col_valid [P_NUM_PE];

    // top boundary row, H(0,c) for the column entering now
    always_comb begin
        top_cell.v = (col_cnt == '0) ? OPEN_EXT : h0_q + EXT;
        top_cell.i = NEG_INF;
        top_cell.d = NEG_INF;
        top_diag   = h0_q;
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            col_cnt <= '0;
        end else if (i_load) begin
            col_cnt <= '0;
        end else if (i_step && i_feed_valid) begin
            col_cnt <= col_cnt + 1'b1;
        end
    end

    // holds H(0, col_cnt)
    always_ff @(posedge i_clk) begin
        if (i_load) begin
            h0_q <= '0;
        end else if (i_step && i_feed_valid) begin
            h0_q <= top_cell.v;
        end
    end

    for (genvar g = 0; g < P_NUM_PE; g++) begin : g_pe
        cell_t  in_top;
        score_t in_diag;
        base_t  in_col;
        logic   in_col_valid;

        if (g == 0) begin : g_first
            assign in_top       = top_cell;
            assign in_diag      = top_diag;
            assign in_col       = i_feed;
            assign in_col_valid = i_feed_valid;
        end else begin : g_chain
            assign in_top       = pe_cell[g-1];
            assign in_diag      = pe_diag[g-1];
            assign in_col       = pe_col[g-1];
            assign in_col_valid = pe_col_valid[g-1];
        end

        sw_pe #(
            .P_ROW        (g),
            .P_GAP_OPEN   (P_GAP_OPEN),
            .P_GAP_EXTEND (P_GAP_EXTEND)
        ) u_sw_pe (
            .i_clk       (i_clk),
            .i_rst       (i_rst),
            .i_load      (i_load),
            .i_step      (i_step),
            .i_row_base  (i_query[g]),
            .i_col       (in_col),
            .i_col_valid (in_col_valid),
            .i_top       (in_top),
            .i_diag      (in_diag),
            .o_cell      (pe_cell[g]),
            .o_diag      (pe_diag[g]),
            .o_col       (pe_col[g]),
            .o_col_valid (pe_col_valid[g])
        );

        // idle rows must not win the step maximum
        assign o_step_v[g] = pe_col_valid[g] ? pe_cell[g].v : NEG_INF;
    end

endmodule

/* design/sw_pkg.sv */
package sw_pkg;

    // signed alignment score
    typedef logic signed [13:0] score_t;

    // one DNA base
    typedef logic [1:0] base_t;

    // query row, from 0
    typedef logic [5:0] row_t;

    // anti-diagonal step or column, from 1
    typedef logic [10:0] step_t;

    localparam score_t NEG_INF        = -14'sd4096;
    localparam score_t MATCH_SCORE    = 14'sd2;
    localparam score_t MISMATCH_SCORE = -14'sd3;

    typedef struct packed {
        base_t base;
        logic  last;
    } sym_t;

    typedef struct packed {
        score_t v;
        score_t i;
        score_t d;
    } cell_t;

    typedef struct packed {
        score_t score;
        row_t   row;
        step_t  col;
        step_t  end_step;
        logic   xdrop_hit;
    } align_result_t;

endpackage

/* project.f */
design/sw_pkg.sv
design/sw_pe.sv
design/sw_pe_array.sv
design/sw_max_tree.sv
design/sw_best_tracker.sv
design/sw_ctrl.sv
design/sw_align_top.sv
test/sw_tb_clk.sv
test/sw_tb.sv

/* test/sw_tb.sv */
`timescale 1ns/100ps

module sw_tb
    import sw_pkg::*;
();

    localparam int NUM_PE    = 8;
    localparam int GAP_OPEN  = -12;
    localparam int GAP_EXT   = -1;
    localparam int XDROP     = 20;
    localparam int MAX_COLS  = 64;
    localparam int MAX_TESTS = 8;
    localparam int TIMEOUT   = 2000;

    logic                 clk;
    logic                 rst;
    logic                 job_req;
    base_t [NUM_PE-1:0]   query_in;
    logic                 job_ack;
    logic                 sym_req;
    sym_t                 sym_in;
    logic                 sym_ack;
    logic                 res_req;
    align_result_t        res;
    logic                 res_ack;

    // stimulus table
    string t_name  [MAX_TESTS];
    string t_query [MAX_TESTS];
    string t_db    [MAX_TESTS];
    bit    t_stop  [MAX_TESTS];
    int    t_stall [MAX_TESTS];
    int    n_tests;

    int error_count;
    int tests_run;
    int tests_clean;
    bit timed_out;

    sw_tb_clk #(
        .P_PERIOD     (10),
        .P_RST_CYCLES (3)
    ) u_sw_tb_clk (
        .o_clk (clk),
        .o_rst (rst)
    );

    sw_align_top #(
        .P_NUM_PE     (NUM_PE),
        .P_GAP_OPEN   (GAP_OPEN),
        .P_GAP_EXTEND (GAP_EXT),
        .P_XDROP      (XDROP)
    ) u_sw_align_top (
        .i_clk     (clk),
        .i_rst     (rst),
        .i_job_req (job_req),
        .i_query   (query_in),
        .o_job_ack (job_ack),
        .i_sym_req (sym_req),
        .i_sym     (sym_in),
        .o_sym_ack (sym_ack),
        .o_res_req (res_req),
        .o_res     (res),
        .i_res_ack (res_ack)
    );

    task automatic add_test(input string name, input string q, input string db,
                            input bit stop, input int stall);
        t_name[n_tests]  = name;
        t_query[n_tests] = q;
        t_db[n_tests]    = db;
        t_stop[n_tests]  = stop;
        t_stall[n_tests] = stall;
        n_tests++;
    endtask

    function automatic base_t to_base(input byte ch);
        case (ch)
            "A": return 2'd0;
            "C": return 2'd1;
            "G": return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    // Gotoh recurrences, then the step maxima and the X-drop rule
    task automatic gotoh_model(input string q, input string db, output int score,
                               output int row, output int col, output int end_step,
                               output bit stop);
        int h [0:NUM_PE][0:MAX_COLS];
        int e [0:NUM_PE][0:MAX_COLS];
        int f [0:NUM_PE][0:MAX_COLS];
        int m;
        int r;
        int c;
        int s;
        int sub;
        int best;
        int smax;
        int srow;
        m = db.len();
        h[0][0] = 0;
        for (c = 1; c <= m; c++) begin
            h[0][c] = GAP_OPEN + GAP_EXT * c;
            e[0][c] = NEG_INF;
            f[0][c] = NEG_INF;
        end
        for (r = 1; r <= NUM_PE; r++) begin
            h[r][0] = GAP_OPEN + GAP_EXT * r;
            e[r][0] = NEG_INF;
            f[r][0] = NEG_INF;
            for (c = 1; c <= m; c++) begin
                sub = (q[r-1] == db[c-1]) ? MATCH_SCORE : MISMATCH_SCORE;
                e[r][c] = h[r][c-1] + GAP_OPEN + GAP_EXT;
                if (e[r][c-1] + GAP_EXT > e[r][c]) begin
                    e[r][c] = e[r][c-1] + GAP_EXT;
                end
                f[r][c] = h[r-1][c] + GAP_OPEN + GAP_EXT;
                if (f[r-1][c] + GAP_EXT > f[r][c]) begin
                    f[r][c] = f[r-1][c] + GAP_EXT;
                end
                h[r][c] = h[r-1][c-1] + sub;
                if (e[r][c] > h[r][c]) begin
                    h[r][c] = e[r][c];
                end
                if (f[r][c] > h[r][c]) begin
                    h[r][c] = f[r][c];
                end
            end
        end
        best     = NEG_INF;
        score    = NEG_INF;
        row      = 0;
        col      = 0;
        stop     = 1'b0;
        end_step = m + NUM_PE - 1;
        s = 1;
        while (s <= m + NUM_PE - 1 && !stop) begin
            smax = NEG_INF - 1;
            srow = 1;
            // ascending rows with >= so the highest row takes ties
            for (r = 1; r <= NUM_PE; r++) begin
                c = s - r + 1;
                if (c >= 1 && c <= m && h[r][c] >= smax) begin
                    smax = h[r][c];
                    srow = r;
                end
            end
            if (smax < best - XDROP) begin
                stop     = 1'b1;
                end_step = s;
            end else if (smax >= best) begin
                best  = smax;
                score = smax;
                row   = srow - 1;
                col   = s - srow + 1;
            end
            s++;
        end
    endtask

    task automatic check_score(input string test, input string what,
                               input score_t exp, input score_t act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %0d, actual %0d", test, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_row(input string test, input string what,
                             input row_t exp, input row_t act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %0d, actual %0d", test, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_step(input string test, input string what,
                              input step_t exp, input step_t act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %0d, actual %0d", test, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_flag(input string test, input string what,
                              input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %0b, actual %0b", test, what, exp, act);
            error_count++;
        end
    endtask

    task automatic stall_cycles(input int max_gap);
        int n;
        n = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst !== 1'b0 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end else begin
            @(negedge clk);
        end
    endtask

    task automatic wait_job_ack(input logic level);
        int n;
        n = 0;
        while (job_ack !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (job_ack !== level) begin
            $display("timeout: o_job_ack never went to %0b", level);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_sym_ack(input logic level);
        int n;
        n = 0;
        while (sym_ack !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (sym_ack !== level) begin
            $display("timeout: o_sym_ack never went to %0b", level);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_res_req(input logic level);
        int n;
        n = 0;
        while (res_req !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (res_req !== level) begin
            $display("timeout: o_res_req never went to %0b", level);
            timed_out = 1'b1;
        end
    endtask

    task automatic send_symbol(input base_t b, input logic last, input int gap);
        stall_cycles(gap);
        sym_in.base = b;
        sym_in.last = last;
        sym_req     = 1'b1;
        wait_sym_ack(1'b1);
        if (timed_out) return;
        stall_cycles(gap);
        sym_req = 1'b0;
        wait_sym_ack(1'b0);
    endtask

    task automatic run_test(input int idx);
        int            m;
        int            k;
        int            exp_score;
        int            exp_row;
        int            exp_col;
        int            exp_end;
        bit            exp_stop;
        int            errs_before;
        align_result_t got;
        m = t_db[idx].len();
        errs_before = error_count;
        gotoh_model(t_query[idx], t_db[idx], exp_score, exp_row, exp_col, exp_end, exp_stop);
        if (exp_stop != t_stop[idx]) begin
            $display("%s: stop flag in the table disagrees with the model", t_name[idx]);
            error_count++;
        end

        stall_cycles(t_stall[idx]);
        for (k = 0; k < NUM_PE; k++) begin
            query_in[k] = to_base(t_query[idx][k]);
        end
        job_req = 1'b1;
        wait_job_ack(1'b1);
        if (timed_out) return;
        stall_cycles(t_stall[idx]);
        job_req = 1'b0;
        wait_job_ack(1'b0);
        if (timed_out) return;

        // every symbol goes out, even after a stop
        for (k = 0; k < m; k++) begin
            send_symbol(to_base(t_db[idx][k]), k == m - 1, t_stall[idx]);
            if (timed_out) return;
        end

        wait_res_req(1'b1);
        if (timed_out) return;
        got = res;
        stall_cycles(t_stall[idx]);
        res_ack = 1'b1;
        wait_res_req(1'b0);
        if (timed_out) return;
        stall_cycles(t_stall[idx]);
        res_ack = 1'b0;

        check_score(t_name[idx], "score", score_t'(exp_score), got.score);
        check_row(t_name[idx], "row", row_t'(exp_row), got.row);
        check_step(t_name[idx], "col", step_t'(exp_col), got.col);
        check_step(t_name[idx], "end_step", step_t'(exp_end), got.end_step);
        check_flag(t_name[idx], "xdrop_hit", t_stop[idx], got.xdrop_hit);

        tests_run++;
        if (error_count == errs_before) begin
            tests_clean++;
        end
        $display("%s finished with %0d errors", t_name[idx], error_count - errs_before);
    endtask

    initial begin
        int unsigned seed;
        int          i;
        int          errs_before;
        seed = 32'h5fe452a9;
        void'($urandom(seed));
        job_req     = 1'b0;
        query_in    = '0;
        sym_req     = 1'b0;
        sym_in      = '0;
        res_ack     = 1'b0;
        n_tests     = 0;
        error_count = 0;
        tests_run   = 0;
        tests_clean = 0;
        timed_out   = 1'b0;

        add_test("identical", "ACGTTGCA", "ACGTTGCA", 1'b0, 2);
        add_test("affine_gap", "ACGTACGT", "ACGTTACGT", 1'b0, 2);
        add_test("xdrop", "AAAAAAAA", "AAAAAAAACCCCCCCCCCCCCCCCCCCCCCCC", 1'b1, 2);
        // runs right after a stop
        add_test("after_stop", "ACGTACGT", "ACGTACGTACGT", 1'b0, 2);
        add_test("stall_gap", "ACGTACGT", "ACGTTACGT", 1'b0, 7);
        add_test("stall_xdrop", "AAAAAAAA", "AAAAAAAACCCCCCCCCCCCCCCCCCCCCCCC", 1'b1, 5);

        wait_reset_release();
        if (!timed_out) begin
            errs_before = error_count;
            check_flag("reset", "o_job_ack", 1'b0, job_ack);
            check_flag("reset", "o_sym_ack", 1'b0, sym_ack);
            check_flag("reset", "o_res_req", 1'b0, res_req);
            tests_run++;
            if (error_count == errs_before) begin
                tests_clean++;
            end
            $display("reset finished with %0d errors", error_count - errs_before);
        end

        for (i = 0; i < n_tests; i++) begin
            if (!timed_out) begin
                run_test(i);
            end
        end

        $display("tests run %0d, without errors %0d, errors %0d",
                 tests_run, tests_clean, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* test/sw_tb_clk.sv */
`timescale 1ns/100ps

module sw_tb_clk #(
    parameter int P_PERIOD     = 10,
    parameter int P_RST_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(P_PERIOD / 2) o_clk = ~o_clk;
    end

    // release on a falling edge, away from the flops
    initial begin
        o_rst = 1'b1;
        repeat (P_RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule
